//--- src/core_pkg.sv
package core_pkg;

  parameter int DATA_WIDTH         = 32;
  parameter int REG_ADDR_WIDTH     = 5;
  parameter int NUM_REGS           = 32;
  parameter int SHAMT_WIDTH        = 5;
  parameter int MUL_STAGES_DEFAULT = 5;

  // RV32 major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  typedef struct packed {
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      uses_rs2;
    logic                      is_mul;
    alu_op_e                   alu_op;
    logic [DATA_WIDTH-1:0]     imm;
  } decoded_t;

endpackage

//--- src/issue_if.sv
`timescale 1ns/10ps

interface issue_if import core_pkg::*; ();

  // Single-cycle strobe, the receiver captures on that edge
  logic                      valid;
  alu_op_e                   alu_op;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic [DATA_WIDTH-1:0]     op_a;
  logic [DATA_WIDTH-1:0]     op_b;

  modport src (
    output valid, alu_op, rd, op_a, op_b
  );

  modport dst (
    input valid, alu_op, rd, op_a, op_b
  );

endinterface

//--- src/reg_bank.sv
`timescale 1ns/10ps

module reg_bank import core_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [REG_ADDR_WIDTH-1:0] rd_a_i,
  input  logic [REG_ADDR_WIDTH-1:0] rd_b_i,
  input  logic                      wr_en_i,
  input  logic [REG_ADDR_WIDTH-1:0] wr_rd_i,
  input  logic [DATA_WIDTH-1:0]     wr_data_i,
  output logic [DATA_WIDTH-1:0]     rd_a_data_o,
  output logic [DATA_WIDTH-1:0]     rd_b_data_o
);

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      regs_q <= '{default: '0};
    end else if (wr_en_i && (wr_rd_i != '0)) begin
      regs_q[wr_rd_i] <= wr_data_i;
    end
  end

  // Same-cycle write is visible to decode
  function automatic logic [DATA_WIDTH-1:0] read_port(input logic [REG_ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en_i && (wr_rd_i == addr)) begin
      data = wr_data_i;
    end else begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  assign rd_a_data_o = read_port(rd_a_i);
  assign rd_b_data_o = read_port(rd_b_i);

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  logic [31:0]           instr_i,
  input  logic                  stall_i,
  input  logic [DATA_WIDTH-1:0] rs1_data_i,
  input  logic [DATA_WIDTH-1:0] rs2_data_i,
  output logic                  dec_valid_o,
  output decoded_t              dec_o,
  issue_if.src                  alu_issue,
  issue_if.src                  mul_issue
);

  logic                  dec_valid_q;
  logic [31:0]           instr_q;
  opcode_e               opcode;
  logic                  supported;
  logic                  issue_ok;
  logic [DATA_WIDTH-1:0] op_b;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dec_valid_q <= 1'b0;
    end else if (!stall_i) begin
      dec_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      instr_q <= instr_i;
    end
  end

  assign opcode = opcode_e'(instr_q[6:0]);

  always_comb begin
    dec_o.rs1      = instr_q[19:15];
    dec_o.rs2      = instr_q[24:20];
    dec_o.rd       = instr_q[11:7];
    dec_o.uses_rs2 = 1'b0;
    dec_o.is_mul   = 1'b0;
    dec_o.alu_op   = ALU_ADD;
    dec_o.imm      = {{(DATA_WIDTH-12){instr_q[31]}}, instr_q[31:20]};
    supported      = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec_o.uses_rs2 = 1'b1;
        supported      = 1'b1;
        // funct7 and funct3 together
        case ({instr_q[31:25], instr_q[14:12]})
          10'b0000000_000: dec_o.alu_op = ALU_ADD;
          10'b0100000_000: dec_o.alu_op = ALU_SUB;
          10'b0000000_111: dec_o.alu_op = ALU_AND;
          10'b0000000_110: dec_o.alu_op = ALU_OR;
          10'b0000000_100: dec_o.alu_op = ALU_XOR;
          10'b0000000_001: dec_o.alu_op = ALU_SLL;
          10'b0000000_101: dec_o.alu_op = ALU_SRL;
          10'b0000001_000: dec_o.is_mul = 1'b1;
          default:         supported = 1'b0;
        endcase
      end
      OPC_OP_IMM: supported = (instr_q[14:12] == 3'b000);
      default:    supported = 1'b0;
    endcase
  end

  // Unsupported and x0 writes are dropped here
  assign issue_ok = dec_valid_q && !stall_i && supported && (dec_o.rd != '0);
  assign op_b     = dec_o.uses_rs2 ? rs2_data_i : dec_o.imm;

  assign alu_issue.valid  = issue_ok && !dec_o.is_mul;
  assign alu_issue.alu_op = dec_o.alu_op;
  assign alu_issue.rd     = dec_o.rd;
  assign alu_issue.op_a   = rs1_data_i;
  assign alu_issue.op_b   = op_b;

  assign mul_issue.valid  = issue_ok && dec_o.is_mul;
  assign mul_issue.alu_op = dec_o.alu_op;
  assign mul_issue.rd     = dec_o.rd;
  assign mul_issue.op_a   = rs1_data_i;
  assign mul_issue.op_b   = op_b;

  assign dec_valid_o = dec_valid_q;

  // Stalled instruction stays on the issue port
  a_hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_i)
    (instr_valid_i && stall_i) |=> (instr_valid_i && $stable(instr_i)));

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import core_pkg::*; #(
  parameter int MUL_STAGES = MUL_STAGES_DEFAULT
) (
  input  logic                      dec_valid_i,
  input  decoded_t                  dec_i,
  input  logic                      alu_busy_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_rd_i,
  input  logic                      alu_hold_i,
  input  logic [MUL_STAGES-1:0]     mul_busy_i,
  input  logic [REG_ADDR_WIDTH-1:0] mul_rd_i [MUL_STAGES],
  output logic                      stall_o
);

  logic                  alu_conflict;
  logic [MUL_STAGES-1:0] mul_conflict;

  // RAW on either source, or WAW on the destination
  function automatic logic conflicts(input decoded_t dec,
                                     input logic [REG_ADDR_WIDTH-1:0] pend_rd);
    logic raw;
    logic waw;
    raw = (pend_rd == dec.rs1) || (dec.uses_rs2 && (pend_rd == dec.rs2));
    waw = (pend_rd == dec.rd);
    return raw || waw;
  endfunction

  assign alu_conflict = alu_busy_i && conflicts(dec_i, alu_rd_i);

  always_comb begin
    for (int i = 0; i < MUL_STAGES; i++) begin
      mul_conflict[i] = mul_busy_i[i] && conflicts(dec_i, mul_rd_i[i]);
    end
  end

  assign stall_o = dec_valid_i && (alu_hold_i || alu_conflict || (|mul_conflict));

endmodule

//--- src/alu_stage.sv
`timescale 1ns/10ps

module alu_stage import core_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  issue_if.dst                      issue,
  input  logic                      grant_i,
  output logic                      busy_o,
  output logic [REG_ADDR_WIDTH-1:0] rd_o,
  output logic                      hold_o,
  output logic                      res_valid_o,
  output logic [DATA_WIDTH-1:0]     res_data_o
);

  logic                      valid_q;
  alu_op_e                   op_q;
  logic [REG_ADDR_WIDTH-1:0] rd_q;
  logic [DATA_WIDTH-1:0]     a_q;
  logic [DATA_WIDTH-1:0]     b_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (issue.valid) begin
      valid_q <= 1'b1;
    end else if (grant_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue.valid) begin
      op_q <= issue.alu_op;
      rd_q <= issue.rd;
      a_q  <= issue.op_a;
      b_q  <= issue.op_b;
    end
  end

  always_comb begin
    case (op_q)
      ALU_ADD: res_data_o = a_q + b_q;
      ALU_SUB: res_data_o = a_q - b_q;
      ALU_AND: res_data_o = a_q & b_q;
      ALU_OR:  res_data_o = a_q | b_q;
      ALU_XOR: res_data_o = a_q ^ b_q;
      ALU_SLL: res_data_o = a_q << b_q[SHAMT_WIDTH-1:0];
      ALU_SRL: res_data_o = a_q >> b_q[SHAMT_WIDTH-1:0];
      default: res_data_o = '0;
    endcase
  end

  assign busy_o      = valid_q;
  assign rd_o        = rd_q;
  assign res_valid_o = valid_q;
  // Result lost arbitration, keep it
  assign hold_o      = valid_q && !grant_i;

  a_no_issue_on_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    hold_o |-> !issue.valid);

endmodule

//--- src/mul_pipe.sv
`timescale 1ns/10ps

module mul_pipe import core_pkg::*; #(
  parameter int MUL_STAGES = MUL_STAGES_DEFAULT
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  issue_if.dst                      issue,
  output logic [MUL_STAGES-1:0]     busy_o,
  output logic [REG_ADDR_WIDTH-1:0] rd_o [MUL_STAGES],
  output logic                      res_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] res_rd_o,
  output logic [DATA_WIDTH-1:0]     res_data_o
);

  logic [MUL_STAGES-1:0]     valid_q;
  logic [REG_ADDR_WIDTH-1:0] rd_q   [MUL_STAGES];
  logic [DATA_WIDTH-1:0]     prod_q [MUL_STAGES];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_STAGES-2:0], issue.valid};
    end
  end

  // Low half of the product is formed up front, the rest is delay
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= issue.rd;
    prod_q[0] <= issue.op_a * issue.op_b;
    for (int i = 1; i < MUL_STAGES; i++) begin
      rd_q[i]   <= rd_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign busy_o      = valid_q;
  assign rd_o        = rd_q;
  assign res_valid_o = valid_q[MUL_STAGES-1];
  assign res_rd_o    = rd_q[MUL_STAGES-1];
  assign res_data_o  = prod_q[MUL_STAGES-1];

endmodule

//--- src/wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter import core_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      alu_valid_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_rd_i,
  input  logic [DATA_WIDTH-1:0]     alu_data_i,
  input  logic                      mul_valid_i,
  input  logic [REG_ADDR_WIDTH-1:0] mul_rd_i,
  input  logic [DATA_WIDTH-1:0]     mul_data_i,
  output logic                      alu_grant_o,
  output logic                      wr_en_o,
  output logic [REG_ADDR_WIDTH-1:0] wr_rd_o,
  output logic [DATA_WIDTH-1:0]     wr_data_o,
  output logic                      wb_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [DATA_WIDTH-1:0]     wb_data_o
);

  // Multiplier cannot stall so it always wins
  assign alu_grant_o = alu_valid_i && !mul_valid_i;
  assign wr_en_o     = mul_valid_i || alu_valid_i;
  assign wr_rd_o     = mul_valid_i ? mul_rd_i : alu_rd_i;
  assign wr_data_o   = mul_valid_i ? mul_data_i : alu_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= wr_en_o;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= wr_rd_o;
    wb_data_o <= wr_data_o;
  end

  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_i)
    wr_en_o |-> (wr_rd_o != '0));

endmodule

//--- src/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import core_pkg::*; #(
  parameter int MUL_STAGES = MUL_STAGES_DEFAULT
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      instr_valid_i,
  input  logic [31:0]               instr_i,
  output logic                      stall_o,
  output logic                      wb_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [DATA_WIDTH-1:0]     wb_data_o
);

  // Decode and register bank
  decoded_t                  dec;
  logic                      dec_valid;
  logic [DATA_WIDTH-1:0]     rs1_data;
  logic [DATA_WIDTH-1:0]     rs2_data;

  // ALU stage
  logic                      alu_busy;
  logic                      alu_hold;
  logic                      alu_grant;
  logic                      alu_res_valid;
  logic [REG_ADDR_WIDTH-1:0] alu_rd;
  logic [DATA_WIDTH-1:0]     alu_res_data;

  // Multiply pipeline
  logic [MUL_STAGES-1:0]     mul_busy;
  logic [REG_ADDR_WIDTH-1:0] mul_rd [MUL_STAGES];
  logic                      mul_res_valid;
  logic [REG_ADDR_WIDTH-1:0] mul_res_rd;
  logic [DATA_WIDTH-1:0]     mul_res_data;

  // Register write
  logic                      wr_en;
  logic [REG_ADDR_WIDTH-1:0] wr_rd;
  logic [DATA_WIDTH-1:0]     wr_data;

  issue_if alu_issue ();
  issue_if mul_issue ();

  decode_stage decode_stage_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall_o),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec),
    .alu_issue     (alu_issue.src),
    .mul_issue     (mul_issue.src)
  );

  hazard_unit #(
    .MUL_STAGES (MUL_STAGES)
  ) hazard_unit_inst (
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .alu_busy_i  (alu_busy),
    .alu_rd_i    (alu_rd),
    .alu_hold_i  (alu_hold),
    .mul_busy_i  (mul_busy),
    .mul_rd_i    (mul_rd),
    .stall_o     (stall_o)
  );

  alu_stage alu_stage_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue       (alu_issue.dst),
    .grant_i     (alu_grant),
    .busy_o      (alu_busy),
    .rd_o        (alu_rd),
    .hold_o      (alu_hold),
    .res_valid_o (alu_res_valid),
    .res_data_o  (alu_res_data)
  );

  mul_pipe #(
    .MUL_STAGES (MUL_STAGES)
  ) mul_pipe_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue       (mul_issue.dst),
    .busy_o      (mul_busy),
    .rd_o        (mul_rd),
    .res_valid_o (mul_res_valid),
    .res_rd_o    (mul_res_rd),
    .res_data_o  (mul_res_data)
  );

  wb_arbiter wb_arbiter_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alu_valid_i (alu_res_valid),
    .alu_rd_i    (alu_rd),
    .alu_data_i  (alu_res_data),
    .mul_valid_i (mul_res_valid),
    .mul_rd_i    (mul_res_rd),
    .mul_data_i  (mul_res_data),
    .alu_grant_o (alu_grant),
    .wr_en_o     (wr_en),
    .wr_rd_o     (wr_rd),
    .wr_data_o   (wr_data),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

  reg_bank reg_bank_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_i      (dec.rs1),
    .rd_b_i      (dec.rs2),
    .wr_en_i     (wr_en),
    .wr_rd_i     (wr_rd),
    .wr_data_i   (wr_data),
    .rd_a_data_o (rs1_data),
    .rd_b_data_o (rs2_data)
  );

endmodule

//--- testbench/tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core;

  localparam int MUL_STAGES    = 5;
  localparam int WAIT_LIMIT    = 200;
  localparam int WB_GAP_LIMIT  = 50;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;
  localparam logic [6:0] F7_MUL  = 7'h01;

  logic        clk_i;
  logic        rst_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        stall_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  integer      seed;
  int          cycle_cnt = 0;
  int          last_accept_cycle = 0;
  int          last_wb_cycle = 0;
  int          exp_count = 0;
  int          wb_count = 0;
  logic [31:0] model [32];
  // Expected results per destination register, oldest first
  logic [31:0] exp_q [32][$];
  int          mul_due_q [$];
  logic [4:0]  mul_rd_q [$];

  cpu_core #(
    .MUL_STAGES (MUL_STAGES)
  ) cpu_core_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_o       (stall_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  // Reference semantics of the kept RV32 subset
  task automatic record_accept(input logic [31:0] instr, input bit check_lat);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    bit          writes;
    bit          is_mul;
    opc = instr[6:0];
    f7 = instr[31:25];
    f3 = instr[14:12];
    rd = instr[11:7];
    a = model[instr[19:15]];
    b = model[instr[24:20]];
    res = '0;
    writes = 1'b1;
    is_mul = 1'b0;
    if (opc == 7'b0110011 && f7 == F7_BASE) begin
      case (f3)
        3'b000:  res = a + b;
        3'b111:  res = a & b;
        3'b110:  res = a | b;
        3'b100:  res = a ^ b;
        3'b001:  res = a << b[4:0];
        3'b101:  res = a >> b[4:0];
        default: writes = 1'b0;
      endcase
    end else if (opc == 7'b0110011 && f7 == F7_ALT && f3 == 3'b000) begin
      res = a - b;
    end else if (opc == 7'b0110011 && f7 == F7_MUL && f3 == 3'b000) begin
      res = a * b;
      is_mul = 1'b1;
    end else if (opc == 7'b0010011 && f3 == 3'b000) begin
      res = a + {{20{instr[31]}}, instr[31:20]};
    end else begin
      writes = 1'b0;
    end
    if (writes && rd != 5'd0) begin
      model[rd] = res;
      last_accept_cycle = cycle_cnt;
      exp_q[rd].push_back(res);
      exp_count++;
      // Accepted on the coming edge, written MUL_STAGES+1 edges later
      if (is_mul && check_lat) begin
        mul_due_q.push_back(cycle_cnt + MUL_STAGES + 2);
        mul_rd_q.push_back(rd);
      end
    end
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input logic [31:0] instr, input bit check_lat);
    int waited;
    waited = 0;
    instr_valid_i = 1'b1;
    instr_i = instr;
    while (stall_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run("issue port stayed stalled past the wait limit");
      end
    end
    record_accept(instr, check_lat);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_total() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run("writebacks still pending after the wait limit");
      end
    end
    // Idle cycles so a stray late writeback still gets caught
    repeat (3) @(negedge clk_i);
  endtask

  task automatic make_alu_instr(output logic [31:0] instr);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r = $random(seed);
    rd = r[4:0];
    rs1 = r[9:5];
    rs2 = r[14:10];
    case (r[18:16])
      3'd0:    instr = enc_r(F7_BASE, 3'b000, rd, rs1, rs2);
      3'd1:    instr = enc_r(F7_ALT, 3'b000, rd, rs1, rs2);
      3'd2:    instr = enc_r(F7_BASE, 3'b111, rd, rs1, rs2);
      3'd3:    instr = enc_r(F7_BASE, 3'b110, rd, rs1, rs2);
      3'd4:    instr = enc_r(F7_BASE, 3'b100, rd, rs1, rs2);
      3'd5:    instr = enc_r(F7_BASE, 3'b001, rd, rs1, rs2);
      3'd6:    instr = enc_r(F7_BASE, 3'b101, rd, rs1, rs2);
      default: instr = enc_addi(rd, rs1, r[30:19]);
    endcase
  endtask

  // Writeback checker, outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      if (wb_valid_o) begin
        wb_count++;
        last_wb_cycle = cycle_cnt;
        assert (exp_q[wb_rd_o].size() > 0)
          else fail_run($sformatf("unexpected writeback to x%0d at %0t", wb_rd_o, $time));
        assert (wb_data_o == exp_q[wb_rd_o][0])
          else fail_run($sformatf("MISMATCH at %0t: x%0d wrote %h, expected %h",
                                  $time, wb_rd_o, wb_data_o, exp_q[wb_rd_o][0]));
        void'(exp_q[wb_rd_o].pop_front());
      end else if (pending_total() != 0 && (cycle_cnt - last_wb_cycle > WB_GAP_LIMIT) &&
                   (cycle_cnt - last_accept_cycle > WB_GAP_LIMIT)) begin
        fail_run("no writeback for too long while results were pending");
      end
      if (mul_due_q.size() > 0) begin
        if (mul_due_q[0] == cycle_cnt) begin
          assert (wb_valid_o && wb_rd_o == mul_rd_q[0])
            else fail_run($sformatf("MISMATCH at %0t: multiply to x%0d not written on time",
                                    $time, mul_rd_q[0]));
          void'(mul_due_q.pop_front());
          void'(mul_rd_q.pop_front());
        end
      end
    end
  end

  a_no_x0_writeback: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_valid_o |-> (wb_rd_o != 5'd0))
    else fail_run("writeback reported for register x0");

  a_outputs_known: assert property (@(posedge clk_i) disable iff (!rst_i)
    !$isunknown({stall_o, wb_valid_o}))
    else fail_run("stall or writeback valid is unknown after reset");

  initial begin
    logic [31:0] instr;
    logic [31:0] r;
    clk_i = 1'b0;
    rst_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    seed = 32'h5c38;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;

    assert (!stall_o && !wb_valid_o)
      else fail_run("stall or writeback active right after reset");
    send(enc_r(F7_BASE, 3'b000, 5'd3, 5'd1, 5'd2), 1'b0);
    wait_drain();

    // Random ALU and ADDI traffic
    for (int i = 0; i < 60; i++) begin
      make_alu_instr(instr);
      send(instr, 1'b0);
    end
    wait_drain();

    // Isolated multiplies, latency is exact
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      send(enc_r(F7_MUL, 3'b000, r[4:0], r[9:5], r[14:10]), 1'b1);
      wait_drain();
    end

    // Dependent chains through both units
    for (int i = 0; i < 8; i++) begin
      send(enc_r(F7_MUL, 3'b000, 5'd5, 5'd5, 5'd6), 1'b0);
      send(enc_r(F7_BASE, 3'b000, 5'd6, 5'd5, 5'd7), 1'b0);
      send(enc_addi(5'd5, 5'd6, 12'h7f3), 1'b0);
      send(enc_r(F7_MUL, 3'b000, 5'd7, 5'd6, 5'd5), 1'b0);
      send(enc_r(F7_BASE, 3'b101, 5'd7, 5'd7, 5'd5), 1'b0);
    end
    wait_drain();

    // One of the ADDIs lands on the multiply writeback edge
    send(enc_r(F7_MUL, 3'b000, 5'd10, 5'd11, 5'd12), 1'b1);
    for (int i = 0; i < 6; i++) begin
      send(enc_addi(5'(20 + i), 5'd13, 12'(17 + i)), 1'b0);
    end
    wait_drain();

    // Discarded: x0 targets and unsupported encodings
    send(enc_r(F7_BASE, 3'b000, 5'd0, 5'd1, 5'd2), 1'b0);
    send(enc_addi(5'd0, 5'd3, 12'h123), 1'b0);
    send(enc_r(F7_MUL, 3'b000, 5'd0, 5'd4, 5'd5), 1'b0);
    send(32'h0000_2383, 1'b0);
    send(enc_r(F7_MUL, 3'b001, 5'd7, 5'd4, 5'd5), 1'b0);
    send({12'h005, 5'd1, 3'b010, 5'd8, 7'b0010011}, 1'b0);
    send(enc_r(F7_ALT, 3'b101, 5'd9, 5'd4, 5'd5), 1'b0);
    send(enc_addi(5'd8, 5'd0, 12'h05a), 1'b0);
    send(enc_r(F7_BASE, 3'b000, 5'd9, 5'd0, 5'd0), 1'b0);
    wait_drain();

    assert (pending_total() == 0 && wb_count == exp_count)
      else fail_run($sformatf("MISMATCH at %0t: %0d writebacks seen, %0d expected",
                              $time, wb_count, exp_count));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- flist.f
src/core_pkg.sv
src/issue_if.sv
src/reg_bank.sv
src/decode_stage.sv
src/hazard_unit.sv
src/alu_stage.sv
src/mul_pipe.sv
src/wb_arbiter.sv
src/cpu_core.sv
testbench/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 --top-module tb_cpu_core -f flist.f -o sim_tb_cpu_core

output=$(./obj_dir/sim_tb_cpu_core || true)
echo "$output"

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
